//--- perfTracePkg.sv
////////////////////////////////////////////////////////////////////////////
// performance sampling and trace unit, shared definitions
// widths, record kinds, counter map, buffer depths and encoder states
////////////////////////////////////////////////////////////////////////////

`default_nettype none

package perfTracePkg;

  // payload and counter widths
  typedef logic [31:0] addr_t;
  typedef logic [31:0] count_t;

  // record fields, kind then tag then payload
  typedef logic [3:0]  recKind_t;
  typedef logic [3:0]  recTag_t;
  typedef logic [39:0] traceRec_t;

  // access port fields
  typedef logic [1:0]  hitCode_t;
  typedef logic [1:0]  accKind_t;

  // record kinds
  localparam recKind_t kindTrain  = 4'd0;
  localparam recKind_t kindBegin  = 4'd1;
  localparam recKind_t kindEnd    = 4'd2;
  localparam recKind_t kindIRead  = 4'd3;
  localparam recKind_t kindDRead  = 4'd4;
  localparam recKind_t kindDWrite = 4'd5;
  localparam recKind_t kindDFlush = 4'd6;
  localparam recKind_t kindCount  = 4'd7;

  // hit codes as reported by the cache
  localparam hitCode_t hitHit   = 2'd0;
  localparam hitCode_t hitMiss  = 2'd1;
  localparam hitCode_t hitEvict = 2'd2;
  localparam hitCode_t hitDirty = 2'd3;

  // access kinds, code 3 is not a legal access
  localparam accKind_t accRead  = 2'd0;
  localparam accKind_t accWrite = 2'd1;
  localparam accKind_t accFlush = 2'd2;

  ////////////////////////////////////////////////////////////////////////////
  // event counters
  ////////////////////////////////////////////////////////////////////////////

  localparam int numCounters = 7;
  typedef logic [2:0] ctrIndex_t;

  localparam ctrIndex_t ctrCycles        = 3'd0;
  localparam ctrIndex_t ctrBranches      = 3'd1;
  localparam ctrIndex_t ctrBranchesTaken = 3'd2;
  localparam ctrIndex_t ctrIcacheAccess  = 3'd3;
  localparam ctrIndex_t ctrIcacheMiss    = 3'd4;
  localparam ctrIndex_t ctrDcacheAccess  = 3'd5;
  localparam ctrIndex_t ctrDcacheMiss    = 3'd6;

  ////////////////////////////////////////////////////////////////////////////
  // buffering and link
  ////////////////////////////////////////////////////////////////////////////

  localparam int fifoDepth    = 16;
  localparam int fifoPtrWidth = $clog2(fifoDepth);
  typedef logic [fifoPtrWidth-1:0] fifoPtr_t;
  // one extra bit so a full buffer can be told from an empty one
  typedef logic [fifoPtrWidth:0]   fifoCount_t;

  localparam int maxCredits = 16;
  typedef logic [4:0] credit_t;

  // encoder is idle or walking through the counter dump
  typedef enum logic {
    encIdle,
    encDump
  } encState_t;

  // assemble one record from its three fields
  function automatic traceRec_t packRec(recKind_t kind, recTag_t tag, count_t payload);
    return {kind, tag, payload};
  endfunction

endpackage

`default_nettype wire

//--- sampleWindow.sv
////////////////////////////////////////////////////////////////////////////
// sample window detection
// single-cycle pulses for reset release and start/stop trigger edges
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module sampleWindow (
  input  logic clk,
  input  logic resetEdge,
  input  logic startTrigger,
  input  logic stopTrigger,
  output logic trainPulse,
  output logic beginPulse,
  output logic endPulse
);

  // reset as seen one clock earlier
  logic resetDelayed;
  // trigger levels from the previous sample
  logic startQ;
  logic stopQ;

  // delayed reset follows the reset line every clock
  always_ff @(posedge clk) begin
    resetDelayed <= resetEdge;
  end

  always_ff @(posedge clk) begin
    if (resetEdge) begin
      startQ     <= 1'b0;
      stopQ      <= 1'b0;
      trainPulse <= 1'b0;
      beginPulse <= 1'b0;
      endPulse   <= 1'b0;
    end else begin
      startQ <= startTrigger;
      stopQ  <= stopTrigger;
      // first clock out of reset marks the training point
      trainPulse <= resetDelayed;
      // rising edges only, so a held level gives a single pulse
      beginPulse <= startTrigger & ~startQ;
      endPulse   <= stopTrigger & ~stopQ;
    end
  end

endmodule

`default_nettype wire

//--- eventCounters.sv
////////////////////////////////////////////////////////////////////////////
// event counters
// free-running counts with snapshots at window begin and frozen deltas
// at window end, read out one index at a time by the encoder
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module eventCounters import perfTracePkg::*; (
  input  logic      clk,
  input  logic      resetEdge,
  input  logic      trainPulse,
  input  logic      beginPulse,
  input  logic      endPulse,
  input  logic      branchRetired,
  input  logic      branchTaken,
  input  logic      accValid,
  input  logic      accSource,
  input  accKind_t  accKind,
  input  hitCode_t  accHit,
  input  ctrIndex_t dumpIndex,
  output count_t    dumpDelta
);

  logic [numCounters-1:0] events;
  count_t counters  [numCounters];
  count_t snapshots [numCounters];
  count_t deltas    [numCounters];

  logic accLegal;
  logic accMiss;
  logic icacheAcc;
  logic dcacheAcc;

  ////////////////////////////////////////////////////////////////////////////
  // event decode
  ////////////////////////////////////////////////////////////////////////////

  // only the three defined access kinds are real accesses
  assign accLegal  = accValid & ((accKind == accRead) | (accKind == accWrite) |
                                 (accKind == accFlush));
  // anything but a clean hit went to the next level
  assign accMiss   = (accHit != hitHit);
  assign icacheAcc = accLegal & ~accSource;
  assign dcacheAcc = accLegal & accSource;

  always_comb begin
    events                   = '0;
    events[ctrCycles]        = 1'b1;
    events[ctrBranches]      = branchRetired;
    events[ctrBranchesTaken] = branchTaken;
    events[ctrIcacheAccess]  = icacheAcc;
    events[ctrIcacheMiss]    = icacheAcc & accMiss;
    events[ctrDcacheAccess]  = dcacheAcc;
    events[ctrDcacheMiss]    = dcacheAcc & accMiss;
  end

  ////////////////////////////////////////////////////////////////////////////
  // counters and snapshots
  ////////////////////////////////////////////////////////////////////////////

  // a counter holds the events of all earlier clocks, so the delta covers
  // the clocks from beginPulse up to the one before endPulse
  always_ff @(posedge clk) begin
    if (resetEdge) begin
      for (int i = 0; i < numCounters; i++) begin
        counters[i]  <= '0;
        snapshots[i] <= '0;
      end
    end else begin
      for (int i = 0; i < numCounters; i++) begin
        // training point restarts every count
        if (trainPulse) counters[i] <= '0;
        else            counters[i] <= counters[i] + count_t'(events[i]);
        if (beginPulse) snapshots[i] <= counters[i];
      end
    end
  end

  // deltas stay frozen while the encoder walks through them
  always_ff @(posedge clk) begin
    if (endPulse) begin
      for (int i = 0; i < numCounters; i++) begin
        deltas[i] <= counters[i] - snapshots[i];
      end
    end
  end

  // index 7 has no counter behind it
  always_comb begin
    if (dumpIndex < ctrIndex_t'(numCounters)) dumpDelta = deltas[dumpIndex];
    else                                      dumpDelta = '0;
  end

endmodule

`default_nettype wire

//--- traceEncoder.sv
////////////////////////////////////////////////////////////////////////////
// trace encoder
// picks one record per clock from markers, cache accesses and the
// counter dump, and counts the accesses that could not be recorded
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module traceEncoder import perfTracePkg::*; (
  input  logic      clk,
  input  logic      resetEdge,
  input  logic      trainPulse,
  input  logic      beginPulse,
  input  logic      endPulse,
  input  logic      accValid,
  input  logic      accSource,
  input  accKind_t  accKind,
  input  hitCode_t  accHit,
  input  addr_t     accAddr,
  input  count_t    dumpDelta,
  input  logic      fifoFull,
  output ctrIndex_t dumpIndex,
  output logic      recValid,
  output traceRec_t recData,
  output count_t    dropCount
);

  encState_t state;
  logic      accLegal;
  logic      markerCycle;
  logic      accDrop;
  logic      nextValid;
  traceRec_t nextData;
  recKind_t  accRecKind;

  // same legality rule as the counters use
  assign accLegal    = accValid & ((accKind == accRead) | (accKind == accWrite) |
                                   (accKind == accFlush));
  assign markerCycle = trainPulse | beginPulse | endPulse;

  // a marker or the dump owns the slot, or there is no room left
  assign accDrop = accLegal & ((state == encDump) | markerCycle | fifoFull);

  // icache only fetches, dcache splits by access kind
  always_comb begin
    if (!accSource)               accRecKind = kindIRead;
    else if (accKind == accWrite) accRecKind = kindDWrite;
    else if (accKind == accFlush) accRecKind = kindDFlush;
    else                          accRecKind = kindDRead;
  end

  ////////////////////////////////////////////////////////////////////////////
  // record select
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    nextValid = 1'b0;
    nextData  = packRec(kindTrain, '0, '0);
    if (state == encDump) begin
      // one count record per clock, tag is the counter index
      nextValid = 1'b1;
      nextData  = packRec(kindCount, {1'b0, dumpIndex}, dumpDelta);
    end else if (trainPulse) begin
      nextValid = 1'b1;
    end else if (beginPulse) begin
      nextValid = 1'b1;
      nextData  = packRec(kindBegin, '0, '0);
    end else if (endPulse) begin
      nextValid = 1'b1;
      nextData  = packRec(kindEnd, '0, '0);
    end else if (accLegal) begin
      nextValid = 1'b1;
      nextData  = packRec(accRecKind, {2'b00, accHit}, accAddr);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // state and outputs
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (resetEdge) begin
      state     <= encIdle;
      dumpIndex <= '0;
      recValid  <= 1'b0;
      dropCount <= '0;
    end else begin
      // a full buffer never sees a push
      recValid  <= nextValid & ~fifoFull;
      dropCount <= dropCount + count_t'(accDrop);
      case (state)
        encIdle: begin
          if (!trainPulse && !beginPulse && endPulse) begin
            state     <= encDump;
            dumpIndex <= '0;
          end
        end
        encDump: begin
          // last counter index ends the dump
          if (dumpIndex == ctrIndex_t'(numCounters - 1)) begin
            state     <= encIdle;
            dumpIndex <= '0;
          end else begin
            dumpIndex <= dumpIndex + 3'd1;
          end
        end
        default: state <= encIdle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (nextValid) recData <= nextData;
  end

endmodule

`default_nettype wire

//--- traceFifo.sv
////////////////////////////////////////////////////////////////////////////
// trace record buffer
// circular buffer between the encoder and the credit transmitter
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module traceFifo import perfTracePkg::*; (
  input  logic      clk,
  input  logic      resetEdge,
  input  logic      push,
  input  traceRec_t pushData,
  input  logic      pop,
  output traceRec_t fifoHead,
  output logic      fifoFull,
  output logic      fifoEmpty
);

  traceRec_t  mem [fifoDepth];
  fifoPtr_t   rdPtr;
  fifoPtr_t   wrPtr;
  fifoCount_t count;
  logic       doPush;
  logic       doPop;

  assign doPop  = pop & (count != '0);
  // a pop in the same clock frees the slot for the push
  assign doPush = push & ((count != fifoCount_t'(fifoDepth)) | doPop);

  always_ff @(posedge clk) begin
    if (doPush) mem[wrPtr] <= pushData;
  end

  // pointers wrap on their own at the power-of-two depth
  always_ff @(posedge clk) begin
    if (resetEdge) begin
      rdPtr <= '0;
      wrPtr <= '0;
      count <= '0;
    end else begin
      if (doPush) wrPtr <= wrPtr + 1'b1;
      if (doPop)  rdPtr <= rdPtr + 1'b1;
      case ({doPush, doPop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  assign fifoHead  = mem[rdPtr];
  assign fifoEmpty = (count == '0);
  // full also when the push now in flight takes the last slot,
  // since the encoder decides one clock ahead of the write
  assign fifoFull  = (count == fifoCount_t'(fifoDepth)) |
                     ((count == fifoCount_t'(fifoDepth - 1)) & push & ~pop);

endmodule

`default_nettype wire

//--- traceCreditTx.sv
////////////////////////////////////////////////////////////////////////////
// credit-based trace transmitter
// sends one buffered record per credit returned by the sink
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module traceCreditTx import perfTracePkg::*; (
  input  logic      clk,
  input  logic      resetEdge,
  input  logic      traceCredit,
  input  logic      fifoEmpty,
  input  traceRec_t fifoHead,
  output logic      pop,
  output logic      traceValid,
  output traceRec_t traceRecord
);

  // credits held, starts at zero until the sink grants some
  credit_t credits;

  // send only with a credit in hand and something to send
  assign pop = (credits != '0) & ~fifoEmpty;

  always_ff @(posedge clk) begin
    if (resetEdge) begin
      credits    <= '0;
      traceValid <= 1'b0;
    end else begin
      traceValid <= pop;
      case ({traceCredit, pop})
        // grant beyond the limit is ignored
        2'b10: begin
          if (credits != credit_t'(maxCredits)) credits <= credits + 1'b1;
        end
        2'b01:   credits <= credits - 1'b1;
        // grant and spend cancel out
        default: credits <= credits;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (pop) traceRecord <= fifoHead;
  end

endmodule

`default_nettype wire

//--- perfTraceTop.sv
////////////////////////////////////////////////////////////////////////////
// performance sampling and trace unit, top level
// window detect, counters, encoder, buffer and credit link
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module perfTraceTop import perfTracePkg::*; (
  input  logic      clk,
  input  logic      resetEdge,
  input  logic      startTrigger,
  input  logic      stopTrigger,
  input  logic      branchRetired,
  input  logic      branchTaken,
  input  logic      accValid,
  input  logic      accSource,
  input  accKind_t  accKind,
  input  hitCode_t  accHit,
  input  addr_t     accAddr,
  input  logic      traceCredit,
  output logic      traceValid,
  output traceRec_t traceRecord,
  output count_t    dropCount
);

  // window pulses
  logic      trainPulse;
  logic      beginPulse;
  logic      endPulse;
  // counter dump
  ctrIndex_t dumpIndex;
  count_t    dumpDelta;
  // encoder to buffer
  logic      recValid;
  traceRec_t recData;
  logic      fifoFull;
  // buffer to transmitter
  logic      pop;
  logic      fifoEmpty;
  traceRec_t fifoHead;

  sampleWindow window_i (
    .clk, .resetEdge, .startTrigger, .stopTrigger,
    .trainPulse, .beginPulse, .endPulse
  );

  eventCounters counters_i (
    .clk, .resetEdge, .trainPulse, .beginPulse, .endPulse,
    .branchRetired, .branchTaken,
    .accValid, .accSource, .accKind, .accHit,
    .dumpIndex, .dumpDelta
  );

  traceEncoder encoder_i (
    .clk, .resetEdge, .trainPulse, .beginPulse, .endPulse,
    .accValid, .accSource, .accKind, .accHit, .accAddr,
    .dumpDelta, .fifoFull,
    .dumpIndex, .recValid, .recData, .dropCount
  );

  traceFifo fifo_i (
    .clk, .resetEdge,
    .push(recValid), .pushData(recData), .pop,
    .fifoHead, .fifoFull, .fifoEmpty
  );

  traceCreditTx tx_i (
    .clk, .resetEdge, .traceCredit, .fifoEmpty, .fifoHead,
    .pop, .traceValid, .traceRecord
  );

endmodule

`default_nettype wire

//--- perfTraceTb.sv
////////////////////////////////////////////////////////////////////////////
// testbench for the performance sampling and trace unit
// random cache accesses, sample windows and credit flow, checked against
// a queue of expected records and model event counters
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module perfTraceTb import perfTracePkg::*; ();

  localparam int clkPeriod = 8;
  // rough cycle budget per test, reset first
  localparam int testCycles = 8 + 30 + 100 + 80 + 80 + 80 + 50;
  localparam int timeoutCycles = testCycles + 200;

  logic      clk;
  logic      resetEdge;
  logic      startTrigger;
  logic      stopTrigger;
  logic      branchRetired;
  logic      branchTaken;
  logic      accValid;
  logic      accSource;
  accKind_t  accKind;
  hitCode_t  accHit;
  addr_t     accAddr;
  logic      traceCredit;
  logic      traceValid;
  traceRec_t traceRecord;
  count_t    dropCount;

  traceRec_t expQ[$];
  count_t    modelCtr[numCounters];
  count_t    dropExpected;
  logic      inWindow;
  logic      creditEnable;
  int        spareCredits;
  integer    seed;
  int        granted;
  int        receivedCount;
  int        errorCount;
  int        checkCount;
  int        testsRun;
  int        testsPassed;
  int        errorsAtStart;
  int        testNum;
  string     testName;

  perfTraceTop dut_i (
    .clk, .resetEdge, .startTrigger, .stopTrigger,
    .branchRetired, .branchTaken,
    .accValid, .accSource, .accKind, .accHit, .accAddr,
    .traceCredit, .traceValid, .traceRecord, .dropCount
  );

  initial begin
    clk = 1'b0;
    forever #(clkPeriod / 2) clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////////////////////

  // kind in the top nibble, then tag, then payload
  function automatic traceRec_t makeRecord(recKind_t kind, recTag_t tag, count_t payload);
    traceRec_t rec;
    rec[39:36] = kind;
    rec[35:32] = tag;
    rec[31:0]  = payload;
    return rec;
  endfunction

  // icache only fetches, dcache kind follows the access kind
  function automatic recKind_t accessKind(logic src, accKind_t kind);
    if (!src) return kindIRead;
    case (kind)
      accWrite: return kindDWrite;
      accFlush: return kindDFlush;
      default:  return kindDRead;
    endcase
  endfunction

  task automatic checkValue(input string what, input logic [39:0] got,
                            input logic [39:0] expected);
    checkCount++;
    if (got !== expected) begin
      errorCount++;
      $display("error at %0t: %s is %h, expected %h", $time, what, got, expected);
    end
  endtask

  // one record leaves the transmitter per traceValid cycle
  always @(negedge clk) begin
    if (!resetEdge && traceValid) begin
      if (expQ.size() == 0) begin
        errorCount++;
        $display("record %h arrived at %0t while none was expected", traceRecord, $time);
      end else begin
        checkValue("trace record", traceRecord, expQ.pop_front());
      end
      receivedCount++;
    end
  end

  // sink grants no more credits than records still on their way,
  // plus any spare ones that probe for records nobody expects
  always @(posedge clk) begin
    if (creditEnable && (granted - receivedCount) < expQ.size() + spareCredits &&
        (granted - receivedCount) < maxCredits) begin
      traceCredit <= 1'b1;
      granted++;
    end else begin
      traceCredit <= 1'b0;
    end
  end

  initial begin
    #(timeoutCycles * clkPeriod);
    $display("watchdog expired after %0d cycles, test %0d (%s) never finished",
             timeoutCycles, testNum, testName);
    $display("Test failed");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // stimulus tasks
  ////////////////////////////////////////////////////////////////////////////

  // one clock of access and branch inputs, model counts inside the window
  task automatic driveCycle(input logic acc, input logic src, input accKind_t kind,
                            input hitCode_t hit, input addr_t addr,
                            input logic br, input logic tk, input logic keep);
    @(posedge clk);
    accValid      <= acc;
    accSource     <= src;
    accKind       <= kind;
    accHit        <= hit;
    accAddr       <= addr;
    branchRetired <= br;
    branchTaken   <= tk;
    if (inWindow) begin
      modelCtr[ctrCycles] += 1;
      if (br) modelCtr[ctrBranches] += 1;
      if (tk) modelCtr[ctrBranchesTaken] += 1;
      if (acc && !src) begin
        modelCtr[ctrIcacheAccess] += 1;
        if (hit != hitHit) modelCtr[ctrIcacheMiss] += 1;
      end
      if (acc && src) begin
        modelCtr[ctrDcacheAccess] += 1;
        if (hit != hitHit) modelCtr[ctrDcacheMiss] += 1;
      end
    end
    if (acc) begin
      if (keep) expQ.push_back(makeRecord(accessKind(src, kind), {2'b00, hit}, addr));
      else      dropExpected += 1;
    end
  endtask

  task automatic idleCycles(input int n);
    repeat (n) driveCycle(1'b0, 1'b0, accRead, hitHit, '0, 1'b0, 1'b0, 1'b1);
  endtask

  // legal access kinds only, branches optional
  task automatic randomCycle(input logic acc, input logic branches, input logic keep);
    logic [31:0] r;
    addr_t       addr;
    accKind_t    kind;
    r    = $random(seed);
    addr = $random(seed);
    kind = (r[1:0] == 2'd3) ? accRead : accKind_t'(r[1:0]);
    driveCycle(acc, r[2], kind, hitCode_t'(r[4:3]), addr,
               branches & r[5], branches & r[5] & r[6], keep);
  endtask

  // start edge opens the model window
  task automatic startWindow();
    @(posedge clk);
    startTrigger <= 1'b1;
    accValid      <= 1'b0;
    branchRetired <= 1'b0;
    branchTaken   <= 1'b0;
    for (int i = 0; i < numCounters; i++) modelCtr[i] = '0;
    inWindow = 1'b1;
    expQ.push_back(makeRecord(kindBegin, '0, '0));
  endtask

  // stop edge closes it, the dump follows the END marker
  task automatic stopWindow();
    @(posedge clk);
    modelCtr[ctrCycles] += 1;
    stopTrigger   <= 1'b1;
    accValid      <= 1'b0;
    branchRetired <= 1'b0;
    branchTaken   <= 1'b0;
    inWindow = 1'b0;
    expQ.push_back(makeRecord(kindEnd, '0, '0));
    for (int i = 0; i < numCounters; i++) begin
      expQ.push_back(makeRecord(kindCount, recTag_t'(i), modelCtr[i]));
    end
  endtask

  task automatic releaseTriggers();
    @(posedge clk);
    startTrigger <= 1'b0;
    stopTrigger  <= 1'b0;
  endtask

  // a few clocks more once the last expected record is in
  task automatic waitDrain();
    while (expQ.size() != 0) @(negedge clk);
    repeat (6) @(negedge clk);
  endtask

  task automatic beginTest(input int num, input string name);
    testNum       = num;
    testName      = name;
    errorsAtStart = errorCount;
  endtask

  task automatic finishTest();
    testsRun++;
    if (errorCount == errorsAtStart) begin
      testsPassed++;
      $display("test %0d %s: passed", testNum, testName);
    end else begin
      $display("test %0d %s: failed with %0d errors", testNum, testName,
               errorCount - errorsAtStart);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    int receivedBefore;
    logic [31:0] r;
    resetEdge     = 1'b1;
    startTrigger  = 1'b0;
    stopTrigger   = 1'b0;
    branchRetired = 1'b0;
    branchTaken   = 1'b0;
    accValid      = 1'b0;
    accSource     = 1'b0;
    accKind       = accRead;
    accHit        = hitHit;
    accAddr       = '0;
    traceCredit   = 1'b0;
    creditEnable  = 1'b0;
    spareCredits  = 0;
    inWindow      = 1'b0;
    dropExpected  = '0;
    seed          = 32'hb296_9d85;
    granted       = 0;
    receivedCount = 0;
    errorCount    = 0;
    checkCount    = 0;
    testsRun      = 0;
    testsPassed   = 0;
    beginTest(0, "reset");
    repeat (8) @(posedge clk);
    resetEdge <= 1'b0;

    // TRAIN marker waits in the buffer until the first credit
    beginTest(1, "training marker");
    expQ.push_back(makeRecord(kindTrain, '0, '0));
    idleCycles(10);
    checkValue("records sent before any credit", receivedCount, 0);
    creditEnable = 1'b1;
    waitDrain();
    finishTest();

    beginTest(2, "random accesses");
    for (int i = 0; i < 40; i++) begin
      randomCycle(1'b1, 1'b0, 1'b1);
      if ($random(seed) & 1) idleCycles(1);
    end
    idleCycles(1);
    waitDrain();
    finishTest();

    // accesses start late enough to miss the BEGIN cycle
    beginTest(3, "sample window");
    startWindow();
    idleCycles(3);
    for (int i = 0; i < 30; i++) begin
      r = $random(seed);
      randomCycle(r[0], 1'b1, 1'b1);
    end
    stopWindow();
    idleCycles(12);
    releaseTriggers();
    waitDrain();
    finishTest();

    beginTest(4, "held triggers");
    idleCycles(2);
    startWindow();
    idleCycles(20);
    stopWindow();
    idleCycles(20);
    releaseTriggers();
    waitDrain();
    finishTest();

    // no credits, so the buffer holds the first 16 and the rest drop
    beginTest(5, "back-pressure");
    creditEnable   = 1'b0;
    receivedBefore = receivedCount;
    for (int i = 0; i < 24; i++) randomCycle(1'b1, 1'b0, i < fifoDepth);
    idleCycles(6);
    checkValue("records sent without credit", receivedCount, receivedBefore);
    checkValue("drop count", dropCount, dropExpected);
    creditEnable = 1'b1;
    waitDrain();
    finishTest();

    // one access in the BEGIN cycle, one during the dump
    beginTest(6, "marker and dump drops");
    startWindow();
    randomCycle(1'b1, 1'b0, 1'b0);
    idleCycles(3);
    stopWindow();
    idleCycles(2);
    randomCycle(1'b1, 1'b0, 1'b0);
    idleCycles(12);
    releaseTriggers();
    waitDrain();
    checkValue("drop count", dropCount, dropExpected);
    // a spare credit must find the buffer empty
    spareCredits = 1;
    idleCycles(8);
    finishTest();

    $display("tests %0d, passed %0d, failed %0d, checks %0d, errors %0d",
             testsRun, testsPassed, testsRun - testsPassed, checkCount, errorCount);
    if (errorCount == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- compile.f
perfTracePkg.sv
sampleWindow.sv
eventCounters.sv
traceEncoder.sv
traceFifo.sv
traceCreditTx.sv
perfTraceTop.sv
perfTraceTb.sv

//--- Bender.yml
package:
  name: perf_trace

sources:
  - perfTracePkg.sv
  - sampleWindow.sv
  - eventCounters.sv
  - traceEncoder.sv
  - traceFifo.sv
  - traceCreditTx.sv
  - perfTraceTop.sv
  - target: simulation
    files:
      - perfTraceTb.sv
